// File: rtl/offload_cfg.svh
/*
 * Offload path configuration
 * Widths, target codes and SSR configuration instruction fields
 */
`ifndef OFFLOAD_CFG_SVH
`define OFFLOAD_CFG_SVH

// Datapath widths
`define OFFLOAD_DATA_W 32
`define OFFLOAD_ID_W   5
`define OFFLOAD_ADDR_W 2

// Target address codes, anything else goes to SNAX
`define OFFLOAD_TGT_HIVE 2'd0
`define OFFLOAD_TGT_SSR  2'd1

// SSR configuration space
`define SSR_NUM_DM   2
`define SSR_NUM_REGS 8

// SSR configuration instruction encoding
`define SSR_OPCODE    7'b0101011
`define SSR_F3_SCFGRI 3'b001
`define SSR_F3_SCFGWI 3'b010
`define SSR_F3_SCFGR  3'b101
`define SSR_F3_SCFGW  3'b110

`endif

// File: rtl/offload_pkg.sv
/*
 * Offload request and response field types
 * Shared by the spill, dispatch, SSR unit and response arbiter
 */
`include "offload_cfg.svh"

package offload_pkg;

  // ------------------------------------------------------------------------
  // Request and response fields
  // ------------------------------------------------------------------------

  // Operand and result word
  typedef logic [`OFFLOAD_DATA_W-1:0] acc_data_t;

  // Destination register id
  typedef logic [`OFFLOAD_ID_W-1:0] acc_id_t;

  // Target address of an offloaded instruction
  typedef logic [`OFFLOAD_ADDR_W-1:0] acc_addr_t;

  // ------------------------------------------------------------------------
  // Targets
  // ------------------------------------------------------------------------

  // Encoding doubles as the arbiter source index
  typedef enum logic [1:0] {
    HIVE = 2'd0,
    SSR  = 2'd1,
    SNAX = 2'd2
  } offload_tgt_e;

endpackage

// File: rtl/ssr_pkg.sv
/*
 * SSR configuration types
 * Instruction word views and the configuration address layout
 */
package ssr_pkg;

  // ------------------------------------------------------------------------
  // Instruction word
  // ------------------------------------------------------------------------

  // I-type field layout, imm12 carries the immediate config address
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_fields_t;

  // Raw view for opcode matching, field view for decoding
  typedef union packed {
    logic [31:0]   raw;
    instr_fields_t fields;
  } instr_word_u;

  // ------------------------------------------------------------------------
  // Configuration address
  // ------------------------------------------------------------------------

  // Register index in the upper bits, data mover in the lower five
  typedef struct packed {
    logic [6:0] reg_idx;
    logic [4:0] dm;
  } ssr_cfg_word_t;

endpackage

// File: rtl/offload_spill.sv
/*
 * Offload request spill register
 * Two entries cut the request path at full throughput, in order
 */
`timescale 1ns/1ns
`include "offload_cfg.svh"

module offload_spill
  import offload_pkg::*;
  import ssr_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  acc_addr_t   in_addr_i,
  input  acc_id_t     in_id_i,
  input  instr_word_u in_instr_i,
  input  acc_data_t   in_arga_i,
  input  acc_data_t   in_argb_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  output acc_addr_t   out_addr_o,
  output acc_id_t     out_id_o,
  output instr_word_u out_instr_o,
  output acc_data_t   out_arga_o,
  output acc_data_t   out_argb_o,
  output logic        out_valid_o,
  input  logic        out_ready_i
);

  localparam int unsigned DataW = `OFFLOAD_ADDR_W + `OFFLOAD_ID_W + 32 + 2 * `OFFLOAD_DATA_W;

  logic [DataW-1:0] in_data;
  logic [DataW-1:0] a_data_q, b_data_q;
  logic             a_full_q, b_full_q;
  logic             a_fill, a_drain, b_fill, b_drain;

  assign in_data = {in_addr_i, in_id_i, in_instr_i, in_arga_i, in_argb_i};

  // Main slot fills from the input, spill slot catches it when stalled
  assign a_fill  = in_valid_i & in_ready_o;
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~out_ready_i;
  assign b_drain = b_full_q & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill | a_drain) a_full_q <= a_fill;
      if (b_fill | b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= in_data;
    if (b_fill) b_data_q <= a_data_q;
  end

  assign in_ready_o  = ~a_full_q | ~b_full_q;
  assign out_valid_o = a_full_q | b_full_q;

  // Spill slot always holds the older item
  assign {out_addr_o, out_id_o, out_instr_o, out_arga_o, out_argb_o} =
      b_full_q ? b_data_q : a_data_q;

endmodule

// File: rtl/offload_dispatch.sv
/*
 * Offload dispatch
 * Steers one request handshake to hive, SSR or SNAX by its address
 */
`timescale 1ns/1ns
`include "offload_cfg.svh"

module offload_dispatch
  import offload_pkg::*;
(
  input  acc_addr_t in_addr_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  output logic      hive_valid_o,
  input  logic      hive_ready_i,
  output logic      ssr_valid_o,
  input  logic      ssr_ready_i,
  output logic      snax_valid_o,
  input  logic      snax_ready_i
);

  offload_tgt_e tgt;

  always_comb begin
    case (in_addr_i)
      `OFFLOAD_TGT_HIVE: tgt = HIVE;
      `OFFLOAD_TGT_SSR:  tgt = SSR;
      default:           tgt = SNAX;
    endcase
  end

  assign hive_valid_o = in_valid_i & (tgt == HIVE);
  assign ssr_valid_o  = in_valid_i & (tgt == SSR);
  assign snax_valid_o = in_valid_i & (tgt == SNAX);

  // Only the selected target may complete the handshake
  always_comb begin
    case (tgt)
      HIVE:    in_ready_o = hive_ready_i;
      SSR:     in_ready_o = ssr_ready_i;
      default: in_ready_o = snax_ready_i;
    endcase
  end

endmodule

// File: rtl/ssr_cfg_unit.sv
/*
 * SSR configuration unit
 * Decodes scfgr/scfgw in both forms, holds the data mover config words
 * and buffers one response
 */
`timescale 1ns/1ns
`include "offload_cfg.svh"

module ssr_cfg_unit
  import offload_pkg::*;
  import ssr_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  acc_id_t     req_id_i,
  input  instr_word_u req_instr_i,
  input  acc_data_t   req_arga_i,
  input  acc_data_t   req_argb_i,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  output acc_id_t     rsp_id_o,
  output acc_data_t   rsp_data_o,
  output logic        rsp_valid_o,
  input  logic        rsp_ready_i
);

  localparam int unsigned DmW  = $clog2(`SSR_NUM_DM);
  localparam int unsigned RegW = $clog2(`SSR_NUM_REGS);

  acc_data_t     cfg_q [`SSR_NUM_DM][`SSR_NUM_REGS];
  ssr_cfg_word_t cfg_word;
  logic          is_ssr, is_write, word_hit, req_fire;
  acc_data_t     rdata;
  logic          rsp_valid_q;
  acc_id_t       rsp_id_q;
  acc_data_t     rsp_data_q;

  // --------------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------------
  assign is_ssr = (req_instr_i.raw[6:0] == `SSR_OPCODE);

  // Unknown instructions fall through as a read of word 0
  always_comb begin
    cfg_word = '0;
    is_write = 1'b0;
    if (is_ssr) begin
      case (req_instr_i.fields.funct3)
        `SSR_F3_SCFGRI: cfg_word = req_instr_i.fields.imm12;
        `SSR_F3_SCFGWI: begin
          cfg_word = req_instr_i.fields.imm12;
          is_write = 1'b1;
        end
        `SSR_F3_SCFGR:  cfg_word = req_argb_i[11:0];
        `SSR_F3_SCFGW: begin
          cfg_word = req_argb_i[11:0];
          is_write = 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign word_hit = (cfg_word.dm < `SSR_NUM_DM) && (cfg_word.reg_idx < `SSR_NUM_REGS);
  assign rdata    = word_hit ? cfg_q[cfg_word.dm[DmW-1:0]][cfg_word.reg_idx[RegW-1:0]] : '0;

  // --------------------------------------------------------------------------
  // Config words and response slot
  // --------------------------------------------------------------------------
  assign req_ready_o = ~rsp_valid_q | rsp_ready_i;
  assign req_fire    = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      for (int d = 0; d < `SSR_NUM_DM; d++) begin
        for (int r = 0; r < `SSR_NUM_REGS; r++) begin
          cfg_q[d][r] <= '0;
        end
      end
      rsp_valid_q <= 1'b0;
    end else begin
      if (req_fire && is_write && word_hit) begin
        cfg_q[cfg_word.dm[DmW-1:0]][cfg_word.reg_idx[RegW-1:0]] <= req_arga_i;
      end
      if (req_fire) rsp_valid_q <= 1'b1;
      else if (rsp_ready_i) rsp_valid_q <= 1'b0;
    end
  end

  // Writes answer with id 0 so the core skips the write-back
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_id_q   <= is_write ? '0 : req_id_i;
      rsp_data_q <= rdata;
    end
  end

  assign rsp_id_o    = rsp_id_q;
  assign rsp_data_o  = rsp_data_q;
  assign rsp_valid_o = rsp_valid_q;

endmodule

// File: rtl/offload_resp_arbiter.sv
/*
 * Offload response arbiter
 * Round-robin merge of the hive, SSR and SNAX response streams
 */
`timescale 1ns/1ns

module offload_resp_arbiter
  import offload_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  acc_id_t   hive_id_i,
  input  acc_data_t hive_data_i,
  input  logic      hive_error_i,
  input  logic      hive_valid_i,
  output logic      hive_ready_o,
  input  acc_id_t   ssr_id_i,
  input  acc_data_t ssr_data_i,
  input  logic      ssr_error_i,
  input  logic      ssr_valid_i,
  output logic      ssr_ready_o,
  input  acc_id_t   snax_id_i,
  input  acc_data_t snax_data_i,
  input  logic      snax_error_i,
  input  logic      snax_valid_i,
  output logic      snax_ready_o,
  output acc_id_t   out_id_o,
  output acc_data_t out_data_o,
  output logic      out_error_o,
  output logic      out_valid_o,
  input  logic      out_ready_i
);

  localparam int unsigned NumSrc = 3;

  logic [NumSrc-1:0] valid_vec;
  offload_tgt_e      rr_q, gnt, gnt_q, sel, cand;
  logic              lock_q;

  assign valid_vec = {snax_valid_i, ssr_valid_i, hive_valid_i};

  // First valid source at or after the pointer wins
  always_comb begin
    gnt  = rr_q;
    cand = rr_q;
    for (int i = NumSrc - 1; i >= 0; i--) begin
      cand = offload_tgt_e'(2'((int'(rr_q) + i) % NumSrc));
      if (valid_vec[cand]) gnt = cand;
    end
  end

  // Grant stays fixed while the output is stalled
  assign sel         = lock_q ? gnt_q : gnt;
  assign out_valid_o = valid_vec[sel];

  always_comb begin
    case (sel)
      HIVE: {out_id_o, out_data_o, out_error_o} = {hive_id_i, hive_data_i, hive_error_i};
      SSR:  {out_id_o, out_data_o, out_error_o} = {ssr_id_i, ssr_data_i, ssr_error_i};
      default: {out_id_o, out_data_o, out_error_o} = {snax_id_i, snax_data_i, snax_error_i};
    endcase
  end

  assign hive_ready_o = out_ready_i & (sel == HIVE);
  assign ssr_ready_o  = out_ready_i & (sel == SSR);
  assign snax_ready_o = out_ready_i & (sel == SNAX);

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      rr_q   <= HIVE;
      gnt_q  <= HIVE;
      lock_q <= 1'b0;
    end else if (out_valid_o && out_ready_i) begin
      rr_q   <= offload_tgt_e'(2'((int'(sel) + 1) % NumSrc));
      lock_q <= 1'b0;
    end else if (out_valid_o) begin
      gnt_q  <= sel;
      lock_q <= 1'b1;
    end
  end

endmodule

// File: rtl/offload_complex.sv
/*
 * Offload complex top level
 * Spill, dispatch to hive/SSR/SNAX and round-robin response return
 */
`timescale 1ns/1ns

module offload_complex
  import offload_pkg::*;
  import ssr_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  acc_addr_t   acc_qaddr_i,
  input  acc_id_t     acc_qid_i,
  input  instr_word_u acc_qdata_op_i,
  input  acc_data_t   acc_qdata_arga_i,
  input  acc_data_t   acc_qdata_argb_i,
  input  logic        acc_qvalid_i,
  output logic        acc_qready_o,
  output acc_data_t   acc_pdata_o,
  output acc_id_t     acc_pid_o,
  output logic        acc_perror_o,
  output logic        acc_pvalid_o,
  input  logic        acc_pready_i,
  output acc_id_t     hive_qid_o,
  output instr_word_u hive_qdata_op_o,
  output acc_data_t   hive_qarga_o,
  output acc_data_t   hive_qargb_o,
  output logic        hive_qvalid_o,
  input  logic        hive_qready_i,
  input  acc_data_t   hive_pdata_i,
  input  acc_id_t     hive_pid_i,
  input  logic        hive_perror_i,
  input  logic        hive_pvalid_i,
  output logic        hive_pready_o,
  output acc_id_t     snax_qid_o,
  output instr_word_u snax_qdata_op_o,
  output acc_data_t   snax_qarga_o,
  output acc_data_t   snax_qargb_o,
  output logic        snax_qvalid_o,
  input  logic        snax_qready_i,
  input  acc_data_t   snax_pdata_i,
  input  acc_id_t     snax_pid_i,
  input  logic        snax_perror_i,
  input  logic        snax_pvalid_i,
  output logic        snax_pready_o
);

  acc_addr_t   sp_addr;
  acc_id_t     sp_id;
  instr_word_u sp_instr;
  acc_data_t   sp_arga, sp_argb;
  logic        sp_valid, sp_ready;
  logic        ssr_qvalid, ssr_qready;
  acc_id_t     ssr_pid;
  acc_data_t   ssr_pdata;
  logic        ssr_pvalid, ssr_pready;

  // --------------------------------------------------------------------------
  // Request path
  // --------------------------------------------------------------------------
  offload_spill i_spill (
    .clk_i, .rst_ni,
    .in_addr_i  (acc_qaddr_i),      .in_id_i    (acc_qid_i),
    .in_instr_i (acc_qdata_op_i),   .in_arga_i  (acc_qdata_arga_i),
    .in_argb_i  (acc_qdata_argb_i), .in_valid_i (acc_qvalid_i),
    .in_ready_o (acc_qready_o),
    .out_addr_o (sp_addr),  .out_id_o    (sp_id),    .out_instr_o (sp_instr),
    .out_arga_o (sp_arga),  .out_argb_o  (sp_argb),  .out_valid_o (sp_valid),
    .out_ready_i (sp_ready)
  );

  offload_dispatch i_dispatch (
    .in_addr_i    (sp_addr),       .in_valid_i   (sp_valid),   .in_ready_o (sp_ready),
    .hive_valid_o (hive_qvalid_o), .hive_ready_i (hive_qready_i),
    .ssr_valid_o  (ssr_qvalid),    .ssr_ready_i  (ssr_qready),
    .snax_valid_o (snax_qvalid_o), .snax_ready_i (snax_qready_i)
  );

  // Payload fans out to both external ports
  assign hive_qid_o      = sp_id;
  assign hive_qdata_op_o = sp_instr;
  assign hive_qarga_o    = sp_arga;
  assign hive_qargb_o    = sp_argb;
  assign snax_qid_o      = sp_id;
  assign snax_qdata_op_o = sp_instr;
  assign snax_qarga_o    = sp_arga;
  assign snax_qargb_o    = sp_argb;

  ssr_cfg_unit i_ssr_cfg (
    .clk_i, .rst_ni,
    .req_id_i   (sp_id),      .req_instr_i (sp_instr),  .req_arga_i  (sp_arga),
    .req_argb_i (sp_argb),    .req_valid_i (ssr_qvalid), .req_ready_o (ssr_qready),
    .rsp_id_o   (ssr_pid),    .rsp_data_o  (ssr_pdata), .rsp_valid_o (ssr_pvalid),
    .rsp_ready_i (ssr_pready)
  );

  // --------------------------------------------------------------------------
  // Response path
  // --------------------------------------------------------------------------
  offload_resp_arbiter i_resp_arb (
    .clk_i, .rst_ni,
    .hive_id_i (hive_pid_i), .hive_data_i (hive_pdata_i), .hive_error_i (hive_perror_i),
    .hive_valid_i (hive_pvalid_i), .hive_ready_o (hive_pready_o),
    .ssr_id_i (ssr_pid), .ssr_data_i (ssr_pdata), .ssr_error_i (1'b0),
    .ssr_valid_i (ssr_pvalid), .ssr_ready_o (ssr_pready),
    .snax_id_i (snax_pid_i), .snax_data_i (snax_pdata_i), .snax_error_i (snax_perror_i),
    .snax_valid_i (snax_pvalid_i), .snax_ready_o (snax_pready_o),
    .out_id_o (acc_pid_o), .out_data_o (acc_pdata_o), .out_error_o (acc_perror_o),
    .out_valid_o (acc_pvalid_o), .out_ready_i (acc_pready_i)
  );

endmodule

// File: tests/offload_props.sv
/*
 * Offload complex handshake properties
 * Bound into the top level to watch its request and response ports
 */
`timescale 1ns/1ns

module offload_props
  import offload_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input acc_data_t acc_pdata_o,
  input acc_id_t   acc_pid_o,
  input logic      acc_perror_o,
  input logic      acc_pvalid_o,
  input logic      acc_pready_i,
  input logic      hive_qvalid_o,
  input logic      snax_qvalid_o
);

  // Reset is active high on rst_ni
  a_resp_stable: assert property (@(posedge clk_i) disable iff (rst_ni)
    acc_pvalid_o && !acc_pready_i |=> acc_pvalid_o && $stable(acc_pdata_o) &&
    $stable(acc_pid_o) && $stable(acc_perror_o))
    else $error("response changed or dropped before it was taken");

  // First edge of reset still sees the power-up state
  a_reset_quiet: assert property (@(posedge clk_i)
    rst_ni && $past(rst_ni) |-> !hive_qvalid_o && !snax_qvalid_o)
    else $error("request valid raised during reset");

  a_one_target: assert property (@(posedge clk_i) disable iff (rst_ni)
    !(hive_qvalid_o && snax_qvalid_o))
    else $error("hive and snax requests raised together");

endmodule

bind offload_complex offload_props i_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .acc_pdata_o   (acc_pdata_o),
  .acc_pid_o     (acc_pid_o),
  .acc_perror_o  (acc_perror_o),
  .acc_pvalid_o  (acc_pvalid_o),
  .acc_pready_i  (acc_pready_i),
  .hive_qvalid_o (hive_qvalid_o),
  .snax_qvalid_o (snax_qvalid_o)
);

// File: tests/tb_offload_complex.sv
/*
 * Offload complex testbench
 * Drives SSR config, hive and SNAX requests, models both external
 * responders and checks every response against a reference model
 */
`timescale 1ns/1ns
`include "offload_cfg.svh"

module tb_offload_complex
  import offload_pkg::*;
  import ssr_pkg::*;
();

  localparam int timeout_cycles = 400;
  localparam int rsp_w = 1 + `OFFLOAD_ID_W + `OFFLOAD_DATA_W;
  localparam int req_w = `OFFLOAD_ID_W + 32 + 2 * `OFFLOAD_DATA_W;

  // Response is {error, id, data}, request is {id, instr, arga, argb}
  typedef logic [rsp_w-1:0] rsp_t;
  typedef logic [req_w-1:0] req_t;

  logic        clk_i, rst_ni;
  acc_addr_t   acc_qaddr_i;
  acc_id_t     acc_qid_i, acc_pid_o, hive_qid_o, hive_pid_i, snax_qid_o, snax_pid_i;
  instr_word_u acc_qdata_op_i, hive_qdata_op_o, snax_qdata_op_o;
  acc_data_t   acc_qdata_arga_i, acc_qdata_argb_i, acc_pdata_o;
  acc_data_t   hive_qarga_o, hive_qargb_o, hive_pdata_i;
  acc_data_t   snax_qarga_o, snax_qargb_o, snax_pdata_i;
  logic        acc_qvalid_i, acc_qready_o, acc_perror_o, acc_pvalid_o, acc_pready_i;
  logic        hive_qvalid_o, hive_qready_i, hive_perror_i, hive_pvalid_i, hive_pready_o;
  logic        snax_qvalid_o, snax_qready_i, snax_perror_i, snax_pvalid_i, snax_pready_o;

  acc_data_t cfg_model [`SSR_NUM_DM][`SSR_NUM_REGS];
  rsp_t      exp_hive [$], exp_ssr [$], exp_snax [$];
  req_t      req_hive [$], req_snax [$];
  rsp_t      pend_hive [$], pend_snax [$];
  logic      hive_taken, snax_taken, stall_en;
  integer    seed;

  offload_complex i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Reference model and checks
  // --------------------------------------------------------------------------
  function automatic logic [11:0] cfg_addr(input int reg_idx, input int dm);
    return {7'(reg_idx), 5'(dm)};
  endfunction

  function automatic logic [31:0] make_instr(input logic [2:0] funct3, input logic [11:0] imm);
    return {imm, 5'd0, funct3, 5'd0, `SSR_OPCODE};
  endfunction

  // External targets answer arga + id, SSR writes update the model
  function automatic rsp_t predict_response(input acc_addr_t addr, input acc_id_t id,
      input logic [31:0] instr, input acc_data_t arga, input acc_data_t argb);
    logic [11:0] ca;
    logic        wr;
    acc_data_t   old;
    if (addr != `OFFLOAD_TGT_SSR) return {id[0], id, arga + 32'(id)};
    ca  = '0;
    wr  = 1'b0;
    old = '0;
    if (instr[6:0] == `SSR_OPCODE) begin
      case (instr[14:12])
        `SSR_F3_SCFGRI: ca = instr[31:20];
        `SSR_F3_SCFGWI: begin
          ca = instr[31:20];
          wr = 1'b1;
        end
        `SSR_F3_SCFGR: ca = argb[11:0];
        `SSR_F3_SCFGW: begin
          ca = argb[11:0];
          wr = 1'b1;
        end
        default: ;
      endcase
    end
    if (ca[4:0] < `SSR_NUM_DM && ca[11:5] < `SSR_NUM_REGS) begin
      old = cfg_model[int'(ca[4:0])][int'(ca[11:5])];
      if (wr) cfg_model[int'(ca[4:0])][int'(ca[11:5])] = arga;
    end
    return {1'b0, wr ? 5'd0 : id, old};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp_val,
      input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      $display("Mismatch at %0t ns: %s expected 0x%08h, got 0x%08h",
               $time, name, exp_val, act_val);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_request(input string port, input req_t exp_req, input acc_id_t id,
      input logic [31:0] instr, input acc_data_t arga, input acc_data_t argb);
    compare_value({port, "_qid_o"}, exp_req[100:96], id);
    compare_value({port, "_qdata_op_o"}, exp_req[95:64], instr);
    compare_value({port, "_qarga_o"}, exp_req[63:32], arga);
    compare_value({port, "_qargb_o"}, exp_req[31:0], argb);
  endtask

  task automatic send_request(input acc_addr_t addr, input acc_id_t id,
      input logic [31:0] instr, input acc_data_t arga, input acc_data_t argb);
    rsp_t rsp;
    int   cnt;
    rsp = predict_response(addr, id, instr, arga, argb);
    if (addr == `OFFLOAD_TGT_HIVE) begin
      exp_hive.push_back(rsp);
      req_hive.push_back({id, instr, arga, argb});
    end else if (addr == `OFFLOAD_TGT_SSR) begin
      exp_ssr.push_back(rsp);
    end else begin
      exp_snax.push_back(rsp);
      req_snax.push_back({id, instr, arga, argb});
    end
    acc_qaddr_i        = addr;
    acc_qid_i          = id;
    acc_qdata_op_i.raw = instr;
    acc_qdata_arga_i   = arga;
    acc_qdata_argb_i   = argb;
    acc_qvalid_i       = 1'b1;
    cnt = 0;
    @(negedge clk_i);
    while (!acc_qready_o) begin
      cnt++;
      if (cnt > timeout_cycles) abort_run("request was never accepted");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    acc_qvalid_i = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Monitor and comparator, sampled mid-cycle
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin
    req_t r;
    rsp_t e;
    if (!rst_ni) begin
      hive_taken = hive_pvalid_i && hive_pready_o;
      snax_taken = snax_pvalid_i && snax_pready_o;
      if (hive_qvalid_o && hive_qready_i) begin
        if (req_hive.size() == 0) abort_run("hive request appeared with none issued");
        r = req_hive.pop_front();
        check_request("hive", r, hive_qid_o, hive_qdata_op_o.raw, hive_qarga_o, hive_qargb_o);
        pend_hive.push_back({hive_qid_o[0], hive_qid_o, hive_qarga_o + 32'(hive_qid_o)});
      end
      if (snax_qvalid_o && snax_qready_i) begin
        if (req_snax.size() == 0) abort_run("snax request appeared with none issued");
        r = req_snax.pop_front();
        check_request("snax", r, snax_qid_o, snax_qdata_op_o.raw, snax_qarga_o, snax_qargb_o);
        pend_snax.push_back({snax_qid_o[0], snax_qid_o, snax_qarga_o + 32'(snax_qid_o)});
      end
      if (acc_pvalid_o && acc_pready_i) begin
        if (hive_taken) begin
          if (exp_hive.size() == 0) abort_run("extra response from hive");
          e = exp_hive.pop_front();
        end else if (snax_taken) begin
          if (exp_snax.size() == 0) abort_run("extra response from snax");
          e = exp_snax.pop_front();
        end else begin
          if (exp_ssr.size() == 0) abort_run("extra response from the SSR unit");
          e = exp_ssr.pop_front();
        end
        compare_value("acc_pid_o", e[36:32], acc_pid_o);
        compare_value("acc_pdata_o", e[31:0], acc_pdata_o);
        compare_value("acc_perror_o", e[37], acc_perror_o);
      end
    end
  end

  // Hive and SNAX responders plus random back-pressure
  always @(posedge clk_i) begin
    #1;
    if (!rst_ni) begin
      if (hive_taken) pend_hive.delete(0);
      if (hive_taken || !hive_pvalid_i) begin
        hive_pvalid_i = (pend_hive.size() > 0) && (($random(seed) & 3) != 0);
        if (pend_hive.size() > 0) {hive_perror_i, hive_pid_i, hive_pdata_i} = pend_hive[0];
      end
      if (snax_taken) pend_snax.delete(0);
      if (snax_taken || !snax_pvalid_i) begin
        snax_pvalid_i = (pend_snax.size() > 0) && (($random(seed) & 3) != 0);
        if (pend_snax.size() > 0) {snax_perror_i, snax_pid_i, snax_pdata_i} = pend_snax[0];
      end
      hive_qready_i = ($random(seed) & 3) != 0;
      snax_qready_i = ($random(seed) & 3) != 0;
      acc_pready_i  = stall_en ? 1'($random(seed)) : 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] r;
    logic [31:0] instr;
    logic [11:0] ca;
    logic [2:0]  f3;
    int          cnt;
    seed = 58;
    stall_en = 1'b0;
    hive_taken = 1'b0;
    snax_taken = 1'b0;
    {acc_qaddr_i, acc_qid_i, acc_qdata_arga_i, acc_qdata_argb_i, acc_qvalid_i} = '0;
    acc_qdata_op_i.raw = '0;
    acc_pready_i = 1'b1;
    {hive_qready_i, hive_pdata_i, hive_pid_i, hive_perror_i, hive_pvalid_i} = '0;
    {snax_qready_i, snax_pdata_i, snax_pid_i, snax_perror_i, snax_pvalid_i} = '0;
    for (int d = 0; d < `SSR_NUM_DM; d++) begin
      for (int g = 0; g < `SSR_NUM_REGS; g++) cfg_model[d][g] = '0;
    end
    rst_ni = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b0;
    @(negedge clk_i);
    compare_value("acc_qready_o", 1, acc_qready_o);
    compare_value("acc_pvalid_o", 0, acc_pvalid_o);
    compare_value("hive_qvalid_o", 0, hive_qvalid_o);
    compare_value("snax_qvalid_o", 0, snax_qvalid_o);
    @(posedge clk_i);
    #1;

    // Immediate write, then read back
    send_request(1, 5'd7, make_instr(`SSR_F3_SCFGWI, cfg_addr(3, 0)), 32'hcafe_0001, '0);
    send_request(1, 5'd8, make_instr(`SSR_F3_SCFGRI, cfg_addr(3, 0)), '0, '0);
    // Register forms reach the same words
    send_request(1, 5'd9, make_instr(`SSR_F3_SCFGW, '0), 32'h1234_5678, 32'(cfg_addr(5, 1)));
    send_request(1, 5'd10, make_instr(`SSR_F3_SCFGRI, cfg_addr(5, 1)), '0, '0);
    send_request(1, 5'd11, make_instr(`SSR_F3_SCFGR, '0), '0, 32'(cfg_addr(3, 0)));
    // Words outside the array
    send_request(1, 5'd12, make_instr(`SSR_F3_SCFGWI, cfg_addr(0, 2)), 32'hdead_beef, '0);
    send_request(1, 5'd13, make_instr(`SSR_F3_SCFGRI, cfg_addr(0, 2)), '0, '0);
    send_request(1, 5'd14, make_instr(`SSR_F3_SCFGW, '0), 32'h0bad_f00d, 32'(cfg_addr(8, 0)));
    send_request(1, 5'd15, make_instr(`SSR_F3_SCFGR, '0), '0, 32'(cfg_addr(8, 0)));
    send_request(1, 5'd16, make_instr(`SSR_F3_SCFGRI, cfg_addr(127, 31)), '0, '0);

    // External targets
    for (int i = 0; i < 12; i++) begin
      r = $random(seed);
      send_request(acc_addr_t'(i % 3 == 0 ? 0 : i % 3 + 1), r[4:0], $random(seed),
                   $random(seed), $random(seed));
    end

    // Mixed traffic under random back-pressure
    stall_en = 1'b1;
    for (int i = 0; i < 80; i++) begin
      r  = $random(seed);
      ca = cfg_addr(r[5:2] % 10, r[7:6]);
      case (r[9:8])
        2'd0:    f3 = `SSR_F3_SCFGRI;
        2'd1:    f3 = `SSR_F3_SCFGWI;
        2'd2:    f3 = `SSR_F3_SCFGR;
        default: f3 = `SSR_F3_SCFGW;
      endcase
      instr = (r[13:10] == 0) ? $random(seed) : make_instr(f3, ca);
      send_request(r[1:0], r[18:14], instr, $random(seed), 32'(ca));
    end
    stall_en = 1'b0;

    cnt = 0;
    while (exp_hive.size() + exp_ssr.size() + exp_snax.size() != 0) begin
      cnt++;
      if (cnt > timeout_cycles) abort_run("responses still outstanding at the end");
      @(negedge clk_i);
    end
    // Let any stray response surface
    repeat (10) @(negedge clk_i);
    $display("Verification passed");
    $finish;
  end

endmodule

// File: project.f
+incdir+rtl
rtl/offload_pkg.sv
rtl/ssr_pkg.sv
rtl/offload_spill.sv
rtl/offload_dispatch.sv
rtl/ssr_cfg_unit.sv
rtl/offload_resp_arbiter.sv
rtl/offload_complex.sv
tests/offload_props.sv
tests/tb_offload_complex.sv

// File: Makefile
# Verilator build and run of the offload complex testbench

VERILATOR ?= verilator
TOP       ?= tb_offload_complex
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
